//--- source/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data word and address width
`define DATA_WIDTH 32

// one strobe per byte lane
`define STRB_WIDTH (`DATA_WIDTH / 8)

// 256 words of data RAM
`define RAM_ADDR_BITS 8

`endif

//--- source/lsu_pkg.sv
`include "lsu_macros.svh"

package lsu_pkg;

  // request kind from the execute stage
  typedef enum logic [1:0] {
    op_none  = 2'b00,
    op_load  = 2'b01,
    op_store = 2'b10
  } lsu_op_e;

  // RV32 funct3 for loads, stores reuse the first three
  typedef enum logic [2:0] {
    f_byte   = 3'b000,
    f_half   = 3'b001,
    f_word   = 3'b010,
    f_byte_u = 3'b100,
    f_half_u = 3'b101
  } mem_funct_e;

  // access sequencer
  typedef enum logic {
    st_idle   = 1'b0,
    st_access = 1'b1
  } lsu_state_e;

  typedef struct packed {
    lsu_op_e                op;
    mem_funct_e             funct3;
    logic [`DATA_WIDTH-1:0] addr;   // execute result
    logic [`DATA_WIDTH-1:0] wdata;  // rs2
  } lsu_req_t;

  typedef struct packed {
    logic                     rd_en;
    logic [`RAM_ADDR_BITS-1:0] index;  // word index
    logic [`STRB_WIDTH-1:0]   wr_strb;
    logic [`DATA_WIDTH-1:0]   wr_data;
  } mem_port_t;

endpackage

//--- source/store_align.sv
`include "lsu_macros.svh"

module store_align (
  input  lsu_pkg::mem_funct_e     funct3,
  input  logic [1:0]              byte_off,
  input  logic [`DATA_WIDTH-1:0]  wdata,
  output logic [`STRB_WIDTH-1:0]  strb,
  output logic [`DATA_WIDTH-1:0]  data
);

  import lsu_pkg::*;

  logic [1:0] half_off;  // offset rounded down to a halfword

  assign half_off = {byte_off[1], 1'b0};

  always_comb begin
    strb = '0;
    data = '0;
    case (funct3)
      f_byte: begin
        strb = `STRB_WIDTH'(4'b0001) << byte_off;
        data = {4{wdata[7:0]}};  // every lane gets the byte
      end
      f_half: begin
        strb = `STRB_WIDTH'(4'b0011) << half_off;
        data = {2{wdata[15:0]}};
      end
      f_word: begin
        strb = '1;  // offset ignored
        data = wdata;
      end
      default: begin
        // unused code writes nothing
        strb = '0;
        data = '0;
      end
    endcase
  end

endmodule

//--- source/load_extend.sv
`include "lsu_macros.svh"

module load_extend (
  input  lsu_pkg::mem_funct_e     funct3,
  input  logic [1:0]              byte_off,
  input  logic [`DATA_WIDTH-1:0]  word,
  output logic [`DATA_WIDTH-1:0]  result
);

  import lsu_pkg::*;

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  // byte lane at the offset
  always_comb begin
    case (byte_off)
      2'd0:    byte_lane = word[7:0];
      2'd1:    byte_lane = word[15:8];
      2'd2:    byte_lane = word[23:16];
      default: byte_lane = word[31:24];
    endcase
  end

  // halfword picked by offset bit 1, bit 0 dropped
  assign half_lane = byte_off[1] ? word[31:16] : word[15:0];

  always_comb begin
    case (funct3)
      f_byte:
        result = {{(`DATA_WIDTH-8){byte_lane[7]}}, byte_lane};
      f_half:
        result = {{(`DATA_WIDTH-16){half_lane[15]}}, half_lane};
      f_word:
        result = word;
      f_byte_u:
        result = {{(`DATA_WIDTH-8){1'b0}}, byte_lane};
      f_half_u:
        result = {{(`DATA_WIDTH-16){1'b0}}, half_lane};
      default:
        result = '0;  // unused code
    endcase
  end

endmodule

//--- source/data_ram.sv
`include "lsu_macros.svh"

module data_ram (
  input  logic                    clk,
  input  lsu_pkg::mem_port_t      mem,
  output logic [`DATA_WIDTH-1:0]  rd_data
);

  import lsu_pkg::*;

  localparam int DEPTH = 2 ** `RAM_ADDR_BITS;

  logic [`DATA_WIDTH-1:0] ram [0:DEPTH-1];

  // byte-strobed write
  always_ff @(posedge clk) begin
    for (int i = 0; i < `STRB_WIDTH; i++) begin
      if (mem.wr_strb[i]) begin
        ram[mem.index][i*8 +: 8] <= mem.wr_data[i*8 +: 8];
      end
    end
  end

  // registered read, zero when idle
  always_ff @(posedge clk) begin
    if (mem.rd_en) begin
      rd_data <= ram[mem.index];
    end else begin
      rd_data <= '0;
    end
  end

endmodule

//--- source/lsu.sv
`include "lsu_macros.svh"

module lsu (
  input  logic                    clk,
  input  logic                    rst_n,
  input  lsu_pkg::lsu_req_t       req,
  output logic                    mem_stall,
  output logic [`DATA_WIDTH-1:0]  lsu_result,
  output lsu_pkg::mem_port_t      mem,
  input  logic [`DATA_WIDTH-1:0]  rd_data
);

  import lsu_pkg::*;

  lsu_state_e state_q;
  lsu_state_e state_d;

  logic                   cycle_a;    // idle with a live request
  logic                   is_load;
  logic                   is_store;
  logic                   load_q;     // cycle B belongs to a load
  mem_funct_e             funct3_q;
  logic [1:0]             off_q;
  logic [`STRB_WIDTH-1:0] strb;
  logic [`DATA_WIDTH-1:0] st_data;
  logic [`DATA_WIDTH-1:0] ld_data;

  assign is_load  = (req.op == op_load);
  assign is_store = (req.op == op_store);
  assign cycle_a  = (state_q == st_idle) && (req.op != op_none);

  assign mem_stall = cycle_a;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (req.op != op_none) state_d = st_access;
      st_access: state_d = st_idle;  // held request ignored
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
      load_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      load_q  <= cycle_a && is_load;
    end
  end

  // load format for cycle B
  always_ff @(posedge clk) begin
    if (cycle_a) begin
      funct3_q <= req.funct3;
      off_q    <= req.addr[1:0];
    end
  end

  store_align u_store_align (
    .funct3   (req.funct3),
    .byte_off (req.addr[1:0]),
    .wdata    (req.wdata),
    .strb     (strb),
    .data     (st_data)
  );

  load_extend u_load_extend (
    .funct3   (funct3_q),
    .byte_off (off_q),
    .word     (rd_data),
    .result   (ld_data)
  );

  // port to the RAM, active only in cycle A
  assign mem.rd_en   = cycle_a && is_load;
  assign mem.index   = req.addr[`RAM_ADDR_BITS+1:2];
  assign mem.wr_strb = (cycle_a && is_store) ? strb : '0;
  assign mem.wr_data = st_data;

  assign lsu_result = (state_q == st_access && load_q) ? ld_data : '0;

endmodule

//--- source/lsu_top.sv
`include "lsu_macros.svh"

module lsu_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  lsu_pkg::lsu_req_t       req,
  output logic                    mem_stall,
  output logic [`DATA_WIDTH-1:0]  lsu_result
);

  import lsu_pkg::*;

  mem_port_t              mem;
  logic [`DATA_WIDTH-1:0] rd_data;

  lsu u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .mem_stall  (mem_stall),
    .lsu_result (lsu_result),
    .mem        (mem),
    .rd_data    (rd_data)
  );

  // data memory behind the unit
  data_ram u_data_ram (
    .clk     (clk),
    .mem     (mem),
    .rd_data (rd_data)
  );

endmodule

//--- test/lsu_checker.sv
`include "lsu_macros.svh"

module lsu_checker (
  input logic                    clk,
  input logic                    rst_n,
  input lsu_pkg::lsu_req_t       req,
  input lsu_pkg::lsu_state_e     state_q,
  input logic                    mem_stall,
  input logic [`DATA_WIDTH-1:0]  lsu_result,
  input lsu_pkg::mem_port_t      mem
);
  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  logic       load_b;     // cycle B of a load
  lsu_state_e exp_state;  // idle/access sequence seen from the request
  int         fail_count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_b    <= 1'b0;
      exp_state <= st_idle;
    end else begin
      load_b <= mem_stall && (req.op == op_load);
      if (exp_state == st_idle && req.op != op_none) begin
        exp_state <= st_access;
      end else begin
        exp_state <= st_idle;
      end
    end
  end

  stall_single: assert property (@(posedge clk) disable iff (!rst_n)
    mem_stall |=> !mem_stall)
    else begin
      fail_count++;
      $error("mem_stall high in two consecutive cycles");
    end

  stall_when_idle_req: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == exp_state) &&
    (mem_stall == ((exp_state == st_idle) && (req.op != op_none))))
    else begin
      fail_count++;
      $error("mem_stall or state does not follow the idle/access sequence");
    end

  strb_store_only: assert property (@(posedge clk) disable iff (!rst_n)
    (mem.wr_strb != '0) |-> (mem_stall && req.op == op_store))
    else begin
      fail_count++;
      $error("write strobes outside cycle A of a store");
    end

  result_load_only: assert property (@(posedge clk) disable iff (!rst_n)
    !load_b |-> (lsu_result == '0))
    else begin
      fail_count++;
      $error("lsu_result nonzero outside cycle B of a load");
    end

endmodule

//--- test/lsu_tb.sv
`include "lsu_macros.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int NBYTES = 4 * (2 ** `RAM_ADDR_BITS);

  logic                   clk;
  logic                   rst_n;
  lsu_req_t               req;
  logic                   mem_stall;
  logic [`DATA_WIDTH-1:0] lsu_result;

  logic [7:0] model [0:NBYTES-1];  // byte image of the RAM
  int errors;
  int checks;
  int tests;
  int failed_tests;

  lsu_top u_lsu_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .mem_stall  (mem_stall),
    .lsu_result (lsu_result)
  );

  bind lsu lsu_checker u_lsu_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .state_q    (state_q),
    .mem_stall  (mem_stall),
    .lsu_result (lsu_result),
    .mem        (mem)
  );

  always #5 clk = ~clk;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $finish;
  endtask

  function automatic void model_store(mem_funct_e f3, logic [31:0] addr, logic [31:0] wdata);
    int a;
    a = int'(addr);
    case (f3)
      f_byte: model[a] = wdata[7:0];
      f_half: for (int i = 0; i < 2; i++) model[(a & ~1) + i] = wdata[8*i +: 8];
      f_word: for (int i = 0; i < 4; i++) model[(a & ~3) + i] = wdata[8*i +: 8];
      default: ;  // nothing written
    endcase
  endfunction

  function automatic logic [31:0] expect_load(mem_funct_e f3, logic [31:0] addr);
    int a;
    int w;
    logic [7:0] b;
    logic [15:0] h;
    a = int'(addr);
    w = a & ~3;
    b = model[a];
    h = {model[(a & ~1) + 1], model[a & ~1]};
    case (f3)
      f_byte:   return {{24{b[7]}}, b};
      f_byte_u: return {24'h0, b};
      f_half:   return {{16{h[15]}}, h};
      f_half_u: return {16'h0, h};
      f_word:   return {model[w + 3], model[w + 2], model[w + 1], model[w]};
      default:  return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] rand_addr(mem_funct_e f3);
    logic [31:0] a;
    a = $urandom % NBYTES;
    case (f3)
      f_byte, f_byte_u: ;
      f_half, f_half_u: a[0] = 1'b0;
      default:          a[1:0] = 2'b00;  // word and unused codes
    endcase
    return a;
  endfunction

  // one request, held until the first cycle with mem_stall low
  task automatic access(input lsu_op_e op, input mem_funct_e f3, input logic [31:0] addr,
                        input logic [31:0] wdata, output logic [31:0] result);
    int stalls;
    req.op     = op;
    req.funct3 = f3;
    req.addr   = addr;
    req.wdata  = wdata;
    stalls     = 0;
    @(negedge clk);
    while (mem_stall && stalls < 10) begin
      stalls++;
      @(negedge clk);
    end
    if (mem_stall) begin
      abort_run("access timed out: mem_stall still high after 10 cycles");
    end else begin
      result = lsu_result;
      checks++;
      if (stalls != 1) begin
        errors++;
        $display("FAIL %0t: access saw %0d stall cycles, expected 1", $time, stalls);
      end
      next_cycle();
      req.op = op_none;
    end
  endtask

  task automatic run_op(input lsu_op_e op, input mem_funct_e f3, input logic [31:0] addr,
                        input logic [31:0] wdata);
    logic [31:0] got;
    logic [31:0] want;
    want = (op == op_load) ? expect_load(f3, addr) : 32'h0;  // stores return zero
    access(op, f3, addr, wdata, got);
    if (op == op_store) model_store(f3, addr, wdata);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0t: %s funct3=%b addr=%h got %h expected %h",
               $time, op.name(), f3, addr, got, want);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %-16s ok", name);
    end else begin
      failed_tests++;
      $display("test %-16s %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int e0;
    int gap;
    int assert_errors;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] q[$];
    mem_funct_e f;
    lsu_op_e op;
    void'($urandom(32'h754c6972));
    clk = 1'b0;
    rst_n = 1'b0;
    req = '0;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    e0 = errors;
    repeat (5) begin
      @(negedge clk);
      checks++;
      if (mem_stall !== 1'b0 || lsu_result !== '0) begin
        errors++;
        $display("FAIL %0t: idle shows stall=%b result=%h", $time, mem_stall, lsu_result);
      end
    end
    next_cycle();
    end_test("idle", e0);

    e0 = errors;
    for (int i = 0; i < NBYTES / 4; i++) begin
      run_op(op_store, f_word, 32'(i * 4), 32'h9e3779b9 * (i + 1) ^ (i << 20));
    end
    end_test("ram_fill", e0);

    e0 = errors;
    run_op(op_store, f_word, 32'h0, 32'hcafe_f00d);
    run_op(op_load, f_word, 32'h0, 32'h0);
    end_test("stall_timing", e0);

    e0 = errors;
    repeat (16) begin
      a = rand_addr(f_word);
      q.push_back(a);
      run_op(op_store, f_word, a, $urandom);
    end
    while (q.size() > 0) run_op(op_load, f_word, q.pop_front(), 32'h0);
    end_test("word_store_load", e0);

    e0 = errors;
    for (int i = 0; i < 40; i++) begin
      f = ($urandom % 2) ? f_half : f_byte;
      a = rand_addr(f);
      d = $urandom;
      if (i % 2 == 0) d = d | 32'h0000_8080;  // force sign bits
      run_op(op_store, f, a, d);
      run_op(op_load, f_byte, a, 32'h0);
      run_op(op_load, f_byte_u, a, 32'h0);
      run_op(op_load, f_byte, a | 32'h1, 32'h0);
      run_op(op_load, f_byte_u, a | 32'h1, 32'h0);
      run_op(op_load, f_half, a & ~32'h1, 32'h0);
      run_op(op_load, f_half_u, a & ~32'h1, 32'h0);
      run_op(op_load, f_word, a & ~32'h3, 32'h0);
    end
    end_test("subword", e0);

    e0 = errors;
    q = {32'd3, 32'd6, 32'd7};  // funct3 codes with no meaning
    foreach (q[i]) begin
      a = rand_addr(f_word);
      run_op(op_store, mem_funct_e'(q[i][2:0]), a, $urandom);
      run_op(op_load, f_word, a, 32'h0);
      run_op(op_load, mem_funct_e'(q[i][2:0]), a, 32'h0);
    end
    end_test("unused_funct3", e0);

    e0 = errors;
    repeat (300) begin
      op = ($urandom % 2) ? op_load : op_store;
      f = mem_funct_e'(3'($urandom % 8));
      a = rand_addr(f);
      run_op(op, f, a, $urandom);
      gap = $urandom % 3;
      repeat (gap) next_cycle();  // idle gap
    end
    end_test("mixed_random", e0);

    assert_errors = u_lsu_top.u_lsu.u_lsu_checker.fail_count;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, failed_tests, checks, errors, assert_errors);
    if (errors == 0 && assert_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
source/lsu_pkg.sv
source/store_align.sv
source/load_extend.sv
source/data_ram.sv
source/lsu.sv
source/lsu_top.sv
test/lsu_checker.sv
test/lsu_tb.sv
